// ==== design/crate_hit_mapper.sv ====
`timescale 1ns/1ns
`include "crate_params.svh"

module crate_hit_mapper
	import crate_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst,
	input  logic [`CRATE_WORD_W-1:0] fiber,
	input  channel_words_t           ch_words,
	output hit_map_t                 map_rows,
	output map_row_t                 header,
	output logic                     map_valid
);

	logic     collect_en;
	logic     report;
	logic     clear_map;
	hit_map_t set_mask;

	frame_sequencer frame_sequencer_inst
	(
		.clk        (clk),
		.rst        (rst),
		.fiber      (fiber),
		.collect_en (collect_en),
		.report     (report),
		.clear_map  (clear_map),
		.header     (header)
	);

	hit_decoder hit_decoder_inst
	(
		.collect_en (collect_en),
		.ch_words   (ch_words),
		.set_mask   (set_mask)
	);

	hit_map hit_map_inst
	(
		.clk       (clk),
		.rst       (rst),
		.set_mask  (set_mask),
		.clear_map (clear_map),
		.report    (report),
		.map_rows  (map_rows)
	);

	// One-cycle frame report
	assign map_valid = report;

endmodule

// ==== design/crate_params.svh ====
`ifndef CRATE_PARAMS_SVH
`define CRATE_PARAMS_SVH

// Channel words per collection cycle
`define CRATE_CHANNELS 16
`define CRATE_WORD_W 16

// Collection cycles per frame and counter width
`define CRATE_COLLECT_CYCLES 16
`define CRATE_COUNT_W 5

// Kept map window, decoded rows 19 to 36
`define CRATE_ROW_FIRST 19
`define CRATE_MAP_ROWS 18
`define CRATE_MAP_COLS 38

`define CRATE_SYNC_WORD 16'hAAAA

// Channel word fields
`define CRATE_HIT_VALID_BIT 12
`define CRATE_FIELD_W 6
`define CRATE_COL_LSB 6
`define CRATE_ROW_LSB 0

// Header fields
`define CRATE_FIBER_ID_W 10
`define CRATE_HEADER_FORMAT 11'd1
`define CRATE_HEADER_FLAG 1'b1

`endif

// ==== design/crate_pkg.sv ====
`include "crate_params.svh"

package crate_pkg;

	// Frame sequencing states
	typedef enum logic [1:0]
	{
		IDLE,
		COLLECT,
		REPORT,
		CLEAR
	} frame_state_t;

	// One map row, bit index is the decoded column
	typedef logic [`CRATE_MAP_COLS-1:0] map_row_t;

	// Index 0 holds decoded row 19
	typedef map_row_t [`CRATE_MAP_ROWS-1:0] hit_map_t;

	// All channel words of one collection cycle
	typedef logic [`CRATE_CHANNELS-1:0][`CRATE_WORD_W-1:0] channel_words_t;

endpackage

// ==== design/frame_sequencer.sv ====
`timescale 1ns/1ns
`include "crate_params.svh"

module frame_sequencer
	import crate_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst,
	input  logic [`CRATE_WORD_W-1:0] fiber,
	output logic                     collect_en,
	output logic                     report,
	output logic                     clear_map,
	output map_row_t                 header
);

	localparam int COUNT_W = `CRATE_COUNT_W;
	localparam logic [COUNT_W-1:0] LAST_CYCLE = COUNT_W'(`CRATE_COLLECT_CYCLES - 1);

	frame_state_t         state;
	logic [COUNT_W-1:0]   cycle_cnt;
	logic                 sync_seen;
	map_row_t             header_next;

	assign sync_seen = (fiber == `CRATE_SYNC_WORD);

	// Flag, format, fiber id, sync pattern
	assign header_next = {
		`CRATE_HEADER_FLAG,
		`CRATE_HEADER_FORMAT,
		fiber[`CRATE_FIBER_ID_W-1:0],
		`CRATE_SYNC_WORD
	};

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= IDLE;
			cycle_cnt <= '0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					cycle_cnt <= '0;
					// Sync only counts while idle
					if (sync_seen)
					begin
						state <= COLLECT;
					end
				end
				COLLECT:
				begin
					cycle_cnt <= cycle_cnt + 1'b1;
					if (cycle_cnt == LAST_CYCLE)
					begin
						state <= REPORT;
					end
				end
				REPORT:
				begin
					state <= CLEAR;
				end
				CLEAR:
				begin
					state <= IDLE;
				end
				default:
				begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Header taken on the edge that leaves REPORT, shown for one cycle only
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			report <= 1'b0;
			header <= '0;
		end
		else
		begin
			report <= (state == REPORT);
			if (state == REPORT)
			begin
				header <= header_next;
			end
			else
			begin
				header <= '0;
			end
		end
	end

	assign collect_en = (state == COLLECT);
	assign clear_map = (state == CLEAR);

	a_report_single: assert property (@(posedge clk) disable iff (rst)
		report |=> !report);

endmodule

// ==== design/hit_decoder.sv ====
`timescale 1ns/1ns
`include "crate_params.svh"

module hit_decoder
	import crate_pkg::*;
(
	input  logic           collect_en,
	input  channel_words_t ch_words,
	output hit_map_t       set_mask
);

	localparam int FIELD_W = `CRATE_FIELD_W;
	localparam int ROW_IDX_W = $clog2(`CRATE_MAP_ROWS);
	localparam logic [FIELD_W-1:0] ROW_FIRST = FIELD_W'(`CRATE_ROW_FIRST);
	localparam logic [FIELD_W-1:0] ROW_LAST = FIELD_W'(`CRATE_ROW_FIRST + `CRATE_MAP_ROWS - 1);
	localparam logic [FIELD_W-1:0] COL_LIMIT = FIELD_W'(`CRATE_MAP_COLS);

	hit_map_t word_mask [`CRATE_CHANNELS];

	// One-hot map bit for a single channel word, or nothing
	function automatic hit_map_t decode_word(input logic [`CRATE_WORD_W-1:0] word);
		logic [FIELD_W-1:0]   col;
		logic [FIELD_W-1:0]   row;
		logic [ROW_IDX_W-1:0] row_idx;
		logic                 in_window;
		hit_map_t             onehot;
		// Both fields carry a plus-one offset, wrapping at 64
		col = word[`CRATE_COL_LSB +: FIELD_W] + 1'b1;
		row = word[`CRATE_ROW_LSB +: FIELD_W] + 1'b1;
		row_idx = ROW_IDX_W'(row - ROW_FIRST);
		in_window = (row >= ROW_FIRST) && (row <= ROW_LAST) && (col < COL_LIMIT);
		onehot = '0;
		if (word[`CRATE_HIT_VALID_BIT] && in_window)
		begin
			onehot[row_idx][col] = 1'b1;
		end
		return onehot;
	endfunction

	genvar ch;
	generate
		for (ch = 0; ch < `CRATE_CHANNELS; ch++)
		begin : g_chan
			assign word_mask[ch] = decode_word(ch_words[ch]);
		end
	endgenerate

	// OR of all channels, zero outside collection
	always_comb
	begin
		set_mask = '0;
		if (collect_en)
		begin
			for (int i = 0; i < `CRATE_CHANNELS; i++)
			begin
				set_mask = set_mask | word_mask[i];
			end
		end
	end

endmodule

// ==== design/hit_map.sv ====
`timescale 1ns/1ns
`include "crate_params.svh"

module hit_map
	import crate_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  hit_map_t set_mask,
	input  logic     clear_map,
	input  logic     report,
	output hit_map_t map_rows
);

	hit_map_t map_q;

	// Accumulate hits until the frame is cleared
	always_ff @(posedge clk)
	begin
		if (rst || clear_map)
		begin
			map_q <= '0;
		end
		else
		begin
			map_q <= map_q | set_mask;
		end
	end

	// Rows visible only in the report cycle
	genvar r;
	generate
		for (r = 0; r < `CRATE_MAP_ROWS; r++)
		begin : g_row
			assign map_rows[r] = report ? map_q[r] : '0;
		end
	endgenerate

	a_cleared: assert property (@(posedge clk) disable iff (rst)
		clear_map |=> (map_q == '0));

	// Map must not move while it is being reported
	a_stable_in_report: assert property (@(posedge clk) disable iff (rst)
		report |-> (set_mask == '0));

endmodule

// ==== project.f ====
+incdir+design
design/crate_pkg.sv
design/frame_sequencer.sv
design/hit_decoder.sv
design/hit_map.sv
design/crate_hit_mapper.sv
verification/tb_crate_hit_mapper.sv

// ==== run.sh ====
#!/bin/sh
# Build the crate hit mapper testbench with Verilator, run it, then scan the log

LOG=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module tb_crate_hit_mapper \
	-f project.f \
	-o tb_crate_hit_mapper \
	|| { echo "Verilator build failed"; exit 1; }

./obj_dir/tb_crate_hit_mapper > "$LOG" 2>&1
cat "$LOG"

grep -q "Done: errors found" "$LOG" && { echo "Simulation failed"; exit 1; }
grep -q "Done: no errors" "$LOG" || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"

// ==== verification/tb_crate_hit_mapper.sv ====
`timescale 1ns/1ns
`include "crate_params.svh"

module tb_crate_hit_mapper
	import crate_pkg::*;
();

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 5;
	localparam int DRIVE_DELAY = 2;
	localparam int NUM_FRAMES = 40;
	localparam int DEDICATED_FRAME = 10;
	localparam int WATCHDOG_CYCLES = NUM_FRAMES * 25 + 50;
	localparam int CHECK_W = 1024;
	localparam int FIELD_SPAN = 1 << `CRATE_FIELD_W;

	logic                     clk;
	logic                     rst;
	logic [`CRATE_WORD_W-1:0] fiber;
	channel_words_t           ch_words;
	hit_map_t                 map_rows;
	map_row_t                 header;
	logic                     map_valid;

	integer   seed;
	hit_map_t exp_map;
	map_row_t exp_header;

	crate_hit_mapper crate_hit_mapper_inst
	(
		.clk       (clk),
		.rst       (rst),
		.fiber     (fiber),
		.ch_words  (ch_words),
		.map_rows  (map_rows),
		.header    (header),
		.map_valid (map_valid)
	);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#(CLK_PERIOD / 2) clk = ~clk;
		end
	end

	task automatic check_value(input string name, input logic [CHECK_W-1:0] expected,
		input logic [CHECK_W-1:0] actual);
		if (actual !== expected)
		begin
			$display("CHECK FAILED time=%0t signal=%s expected=%0h actual=%0h",
				$time, name, expected, actual);
			$display("Done: errors found");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	function automatic int rand_below(input int limit);
		logic [31:0] r;
		r = $random(seed);
		return int'(r % limit);
	endfunction

	// Random upper bits, chosen valid flag and fields
	function automatic logic [`CRATE_WORD_W-1:0] make_word(input logic valid,
		input int row_field, input int col_field);
		logic [`CRATE_WORD_W-1:0] word;
		word = `CRATE_WORD_W'($random(seed));
		word[`CRATE_HIT_VALID_BIT] = valid;
		word[`CRATE_COL_LSB +: `CRATE_FIELD_W] = `CRATE_FIELD_W'(col_field);
		word[`CRATE_ROW_LSB +: `CRATE_FIELD_W] = `CRATE_FIELD_W'(row_field);
		return word;
	endfunction

	// Mostly inside the window so the map fills up
	function automatic logic [`CRATE_WORD_W-1:0] hit_word();
		int row_field;
		int col_field;
		if (rand_below(4) != 0)
			row_field = `CRATE_ROW_FIRST - 1 + rand_below(`CRATE_MAP_ROWS);
		else
			row_field = rand_below(FIELD_SPAN);
		if (rand_below(4) != 0)
			col_field = rand_below(`CRATE_MAP_COLS - 1);
		else
			col_field = rand_below(FIELD_SPAN);
		return make_word(rand_below(2) == 1, row_field, col_field);
	endfunction

	// Words that must never touch the map
	function automatic logic [`CRATE_WORD_W-1:0] reject_word();
		int row_ok;
		int col_ok;
		row_ok = `CRATE_ROW_FIRST - 1 + rand_below(`CRATE_MAP_ROWS);
		col_ok = rand_below(`CRATE_MAP_COLS - 1);
		case (rand_below(4))
			0: return make_word(1'b0, row_ok, col_ok);
			1: return make_word(1'b1, rand_below(`CRATE_ROW_FIRST - 1), col_ok);
			2: return make_word(1'b1, `CRATE_ROW_FIRST + `CRATE_MAP_ROWS - 1
				+ rand_below(FIELD_SPAN - `CRATE_ROW_FIRST - `CRATE_MAP_ROWS + 1), col_ok);
			default: return make_word(1'b1, row_ok,
				`CRATE_MAP_COLS - 1 + rand_below(FIELD_SPAN - `CRATE_MAP_COLS));
		endcase
	endfunction

	function automatic channel_words_t random_words();
		channel_words_t words;
		for (int ch = 0; ch < `CRATE_CHANNELS; ch++)
		begin
			words[ch] = `CRATE_WORD_W'($random(seed));
		end
		return words;
	endfunction

	function automatic logic [`CRATE_WORD_W-1:0] idle_fiber();
		logic [`CRATE_WORD_W-1:0] value;
		value = `CRATE_WORD_W'($random(seed));
		if (value == `CRATE_SYNC_WORD)
			value = ~value;
		return value;
	endfunction

	// Reference decode, fields are offset by one and wrap at 64
	task automatic model_word(input logic [`CRATE_WORD_W-1:0] word);
		int       col;
		int       row;
		logic [4:0] row_idx;
		logic [5:0] col_idx;
		col = (int'(word[`CRATE_COL_LSB +: `CRATE_FIELD_W]) + 1) % FIELD_SPAN;
		row = (int'(word[`CRATE_ROW_LSB +: `CRATE_FIELD_W]) + 1) % FIELD_SPAN;
		if (word[`CRATE_HIT_VALID_BIT] && row >= `CRATE_ROW_FIRST
			&& row < `CRATE_ROW_FIRST + `CRATE_MAP_ROWS && col < `CRATE_MAP_COLS)
		begin
			row_idx = 5'(row - `CRATE_ROW_FIRST);
			col_idx = 6'(col);
			exp_map[row_idx][col_idx] = 1'b1;
		end
	endtask

	task automatic check_outputs(input logic report_due);
		if (report_due)
		begin
			check_value("map_valid", CHECK_W'(1'b1), CHECK_W'(map_valid));
			check_value("map_rows", CHECK_W'(exp_map), CHECK_W'(map_rows));
			check_value("header", CHECK_W'(exp_header), CHECK_W'(header));
		end
		else
		begin
			check_value("map_valid", '0, CHECK_W'(map_valid));
			check_value("map_rows", '0, CHECK_W'(map_rows));
			check_value("header", '0, CHECK_W'(header));
		end
	endtask

	// Outputs are registered, so they are settled by the drive point
	task automatic advance(input logic report_due);
		@(posedge clk);
		#(DRIVE_DELAY);
		check_outputs(report_due);
	endtask

	task automatic run_frame(input int gap, input logic dedicated);
		logic [`CRATE_WORD_W-1:0] report_fiber;
		for (int c = 0; c < gap; c++)
		begin
			fiber = idle_fiber();
			ch_words = random_words();
			advance(1'b0);
		end
		fiber = `CRATE_SYNC_WORD;
		ch_words = random_words();
		advance(1'b0);
		exp_map = '0;
		for (int c = 1; c <= `CRATE_COLLECT_CYCLES; c++)
		begin
			if (dedicated)
			begin
				for (int ch = 0; ch < `CRATE_CHANNELS; ch++)
					ch_words[ch] = reject_word();
				// Two known hits at the window edges
				if (c == 5)
					ch_words[3] = make_word(1'b1, 18, 63);
				if (c == `CRATE_COLLECT_CYCLES)
					ch_words[15] = make_word(1'b1, 35, 36);
				// Repeated sync inside the frame
				if (c == 4 || c == 9 || c == `CRATE_COLLECT_CYCLES)
					fiber = `CRATE_SYNC_WORD;
				else
					fiber = idle_fiber();
			end
			else
			begin
				for (int ch = 0; ch < `CRATE_CHANNELS; ch++)
				begin
					ch_words[ch] = hit_word();
					model_word(ch_words[ch]);
				end
				fiber = `CRATE_WORD_W'($random(seed));
			end
			advance(1'b0);
		end
		if (dedicated)
		begin
			exp_map = '0;
			exp_map[0][0] = 1'b1;
			exp_map[17][37] = 1'b1;
			report_fiber = `CRATE_SYNC_WORD;
		end
		else
		begin
			report_fiber = `CRATE_WORD_W'($random(seed));
		end
		exp_header = {1'b1, `CRATE_HEADER_FORMAT, report_fiber[`CRATE_FIBER_ID_W-1:0],
			`CRATE_SYNC_WORD};
		fiber = report_fiber;
		ch_words = random_words();
		advance(1'b1);
		fiber = dedicated ? `CRATE_SYNC_WORD : idle_fiber();
		ch_words = random_words();
		advance(1'b0);
	endtask

	initial
	begin
		int gap;
		seed = 86;
		rst = 1'b1;
		fiber = '0;
		ch_words = '0;
		exp_map = '0;
		exp_header = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#(DRIVE_DELAY);
		rst = 1'b0;
		check_outputs(1'b0);
		for (int f = 0; f < NUM_FRAMES; f++)
		begin
			// Every fourth frame starts on the earliest accepted edge
			if (f % 4 == 3)
				gap = 0;
			else
				gap = rand_below(6);
			run_frame(gap, f == DEDICATED_FRAME);
		end
		$display("Done: no errors");
		$finish;
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: the test did not finish within %0d clock cycles", WATCHDOG_CYCLES);
		$display("Done: errors found");
		$fatal(1, "Watchdog expired");
	end

endmodule
